// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_ooo_core
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit #(
    parameter  int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEF,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             disp_valid,
    input  wire rob_pkg::issue_t  disp,
    input  wire logic [TAG_W-1:0] disp_tag,
    wb_if.source                  wb
);

    localparam int XLEN = rob_pkg::XLEN;

    logic            accept;                     // Dispatch is for this unit
    logic            slt;                        // Signed less-than
    logic [XLEN-1:0] result;

    // Drop anything dispatched while the buffer flushes
    assign accept = disp_valid && (disp.unit == rob_pkg::UNIT_ALU) && !wb.kill;

    assign slt = $signed(disp.op_a) < $signed(disp.op_b);

    always_comb begin
        case (disp.alu_op)
            rob_pkg::ALU_ADD: result = disp.op_a + disp.op_b;
            rob_pkg::ALU_SUB: result = disp.op_a - disp.op_b;
            rob_pkg::ALU_AND: result = disp.op_a & disp.op_b;
            rob_pkg::ALU_OR:  result = disp.op_a | disp.op_b;
            rob_pkg::ALU_XOR: result = disp.op_a ^ disp.op_b;
            rob_pkg::ALU_SLT: result = {{(XLEN-1){1'b0}}, slt}; // 0 or 1
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || wb.kill) begin
            wb.valid <= 1'b0;                    // Kill drops the pending result
        end else begin
            wb.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb.tag   <= disp_tag;                // Buffer entry from allocation
            wb.value <= result;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     issue_valid,
    input  wire logic [31:0]              issue_instr,
    input  wire logic [rob_pkg::XLEN-1:0] issue_pc,
    input  wire logic [rob_pkg::XLEN-1:0] issue_op_a,
    input  wire logic [rob_pkg::XLEN-1:0] issue_op_b,
    output      logic                     disp_valid,
    output      rob_pkg::issue_t          disp
);

    logic [6:0]      opcode;                     // instr[6:0]
    logic [4:0]      rd;                         // instr[11:7]
    logic [2:0]      funct3;                     // instr[14:12]
    logic [6:0]      funct7;                     // instr[31:25]
    rob_pkg::issue_t dec;                        // Decoded, not yet registered

    assign opcode = issue_instr[6:0];
    assign rd     = issue_instr[11:7];
    assign funct3 = issue_instr[14:12];
    assign funct7 = issue_instr[31:25];

    always_comb begin
        dec.unit    = rob_pkg::UNIT_NONE;        // Assume illegal until matched
        dec.alu_op  = rob_pkg::ALU_ADD;
        dec.illegal = 1'b1;
        dec.rd      = rd;
        dec.pc      = issue_pc;
        dec.op_a    = issue_op_a;
        dec.op_b    = issue_op_b;
        if (opcode == rob_pkg::OPC_OP) begin
            case (funct7)
                rob_pkg::F7_BASE: begin
                    dec.unit    = rob_pkg::UNIT_ALU;
                    dec.illegal = 1'b0;
                    case (funct3)
                        3'b000:  dec.alu_op = rob_pkg::ALU_ADD;
                        3'b010:  dec.alu_op = rob_pkg::ALU_SLT;
                        3'b100:  dec.alu_op = rob_pkg::ALU_XOR;
                        3'b110:  dec.alu_op = rob_pkg::ALU_OR;
                        3'b111:  dec.alu_op = rob_pkg::ALU_AND;
                        default: begin                 // SLL, SLTU, SRL not supported
                            dec.unit    = rob_pkg::UNIT_NONE;
                            dec.illegal = 1'b1;
                        end
                    endcase
                end
                rob_pkg::F7_SUB: begin
                    if (funct3 == 3'b000) begin        // SUB only, SRA rejected
                        dec.unit    = rob_pkg::UNIT_ALU;
                        dec.alu_op  = rob_pkg::ALU_SUB;
                        dec.illegal = 1'b0;
                    end
                end
                rob_pkg::F7_MULDIV: begin
                    if (funct3 == 3'b000) begin        // MUL, low half of product
                        dec.unit    = rob_pkg::UNIT_MUL;
                        dec.illegal = 1'b0;
                    end
                end
                default: ;                             // Stays illegal
            endcase
        end
        dec.reg_write = !dec.illegal && (rd != 5'd0);  // x0 never written
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_valid <= 1'b0;
        end else begin
            disp_valid <= issue_valid;                 // One cycle issue to dispatch
        end
    end

    always_ff @(posedge clk) begin
        disp <= dec;                                   // Payload, no reset needed
    end

endmodule

`default_nettype wire

// ==== hdl/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_unit #(
    parameter  int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEF,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             disp_valid,
    input  wire rob_pkg::issue_t  disp,
    input  wire logic [TAG_W-1:0] disp_tag,
    wb_if.source                  wb
);

    localparam int XLEN = rob_pkg::XLEN;
    localparam int HALF = XLEN / 2;              // Partial product split

    logic            accept;
    logic            s1_valid;                   // Stage 1 operand capture
    logic [TAG_W-1:0] s1_tag;
    logic [XLEN-1:0] s1_a;
    logic [XLEN-1:0] s1_b;
    logic            s2_valid;                   // Stage 2 partial products
    logic [TAG_W-1:0] s2_tag;
    logic [XLEN-1:0] s2_ll;                      // Full width a_lo * b_lo
    logic [HALF-1:0] s2_cross;                   // Low halves of cross terms
    logic [XLEN-1:0] pp_ll;
    logic [HALF-1:0] pp_lh;                      // Only the low half reaches the result
    logic [HALF-1:0] pp_hl;

    assign accept = disp_valid && (disp.unit == rob_pkg::UNIT_MUL) && !wb.kill;

    // High x high only touches bits above XLEN, so it is skipped
    assign pp_ll = s1_a[HALF-1:0] * s1_b[HALF-1:0];
    assign pp_lh = s1_a[HALF-1:0] * s1_b[XLEN-1:HALF];
    assign pp_hl = s1_a[XLEN-1:HALF] * s1_b[HALF-1:0];

    always_ff @(posedge clk) begin
        if (rst || wb.kill) begin
            s1_valid <= 1'b0;                    // Flush every stage at once
            s2_valid <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
            wb.valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag   <= disp_tag;
        s1_a     <= disp.op_a;
        s1_b     <= disp.op_b;
        s2_tag   <= s1_tag;
        s2_ll    <= pp_ll;
        s2_cross <= pp_lh + pp_hl;                     // Carry out past XLEN dropped
        wb.tag   <= s2_tag;
        wb.value <= s2_ll + {s2_cross, {HALF{1'b0}}};  // Low XLEN bits of product
    end

endmodule

`default_nettype wire

// ==== hdl/ooo_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top #(
    parameter  int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEF,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     issue_valid,
    input  wire logic [31:0]              issue_instr,
    input  wire logic [rob_pkg::XLEN-1:0] issue_pc,
    input  wire logic [rob_pkg::XLEN-1:0] issue_op_a,
    input  wire logic [rob_pkg::XLEN-1:0] issue_op_b,
    output      logic                     rob_full,
    output      logic                     commit_valid,
    output      logic [4:0]               commit_rd,
    output      logic [rob_pkg::XLEN-1:0] commit_value,
    output      logic                     commit_reg_write,
    output      logic [rob_pkg::XLEN-1:0] commit_pc,
    output      logic                     excp_valid,
    output      logic [rob_pkg::XLEN-1:0] excp_pc
);

    logic             disp_valid;                // Dispatch strobe from decode
    rob_pkg::issue_t  disp;
    logic [TAG_W-1:0] disp_tag;                  // Tail index from the buffer

    wb_if #(.ROB_DEPTH(ROB_DEPTH)) wb_alu ();    // ALU to buffer
    wb_if #(.ROB_DEPTH(ROB_DEPTH)) wb_mul ();    // Multiplier to buffer

    inst_decode i_inst_decode (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .issue_pc    (issue_pc),
        .issue_op_a  (issue_op_a),
        .issue_op_b  (issue_op_b),
        .disp_valid  (disp_valid),
        .disp        (disp)
    );

    alu_unit #(.ROB_DEPTH(ROB_DEPTH)) i_alu_unit (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp       (disp),
        .disp_tag   (disp_tag),
        .wb         (wb_alu.source)
    );

    mul_unit #(.ROB_DEPTH(ROB_DEPTH)) i_mul_unit (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp       (disp),
        .disp_tag   (disp_tag),
        .wb         (wb_mul.source)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) i_reorder_buffer (
        .clk              (clk),
        .rst              (rst),
        .disp_valid       (disp_valid),
        .disp             (disp),
        .disp_tag         (disp_tag),
        .rob_full         (rob_full),
        .wb_alu           (wb_alu.sink),
        .wb_mul           (wb_mul.sink),
        .commit_valid     (commit_valid),
        .commit_rd        (commit_rd),
        .commit_value     (commit_value),
        .commit_reg_write (commit_reg_write),
        .commit_pc        (commit_pc),
        .excp_valid       (excp_valid),
        .excp_pc          (excp_pc)
    );

endmodule

`default_nettype wire

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter  int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEF,
    localparam int TAG_W     = $clog2(ROB_DEPTH)
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     disp_valid,
    input  wire rob_pkg::issue_t          disp,
    output      logic [TAG_W-1:0]         disp_tag,
    output      logic                     rob_full,
    wb_if.sink                            wb_alu,
    wb_if.sink                            wb_mul,
    output      logic                     commit_valid,
    output      logic [4:0]               commit_rd,
    output      logic [rob_pkg::XLEN-1:0] commit_value,
    output      logic                     commit_reg_write,
    output      logic [rob_pkg::XLEN-1:0] commit_pc,
    output      logic                     excp_valid,
    output      logic [rob_pkg::XLEN-1:0] excp_pc
);

    localparam int XLEN  = rob_pkg::XLEN;
    localparam int CNT_W = TAG_W + 1;            // Counts 0 to ROB_DEPTH

    // Entry state, busy is the only flag that needs reset
    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] rdy;                   // Result present
    logic [ROB_DEPTH-1:0] excp;                  // Illegal instruction entry
    logic [4:0]           rd_q     [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] wr_q;                  // Register-write flag
    logic [XLEN-1:0]      value_q  [ROB_DEPTH];
    logic [XLEN-1:0]      pc_q     [ROB_DEPTH];

    logic [TAG_W-1:0]     head;                  // Oldest entry
    logic [TAG_W-1:0]     tail;                  // Next free entry
    logic [CNT_W-1:0]     count;
    logic                 kill_q;                // Flush strobe to the units

    logic                 alloc;
    logic                 head_done;
    logic                 commit_fire;
    logic                 excp_fire;

    assign disp_tag = tail;                      // Tag handed out in dispatch cycle
    assign rob_full = (count == CNT_W'(ROB_DEPTH));

    assign wb_alu.kill = kill_q;
    assign wb_mul.kill = kill_q;

    // Dispatch in the flush cycle belongs to the dropped stream
    assign alloc       = disp_valid && !kill_q;
    assign head_done   = busy[head] && rdy[head];
    assign commit_fire = head_done && !excp[head];
    assign excp_fire   = head_done && excp[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
            excp_valid   <= 1'b0;
            kill_q       <= 1'b0;
        end else begin
            commit_valid <= commit_fire;         // Strobes last one cycle
            excp_valid   <= excp_fire;
            kill_q       <= excp_fire;
            if (excp_fire) begin
                busy  <= '0;                     // Flush all, younger dispatch too
                head  <= '0;
                tail  <= '0;
                count <= '0;
            end else begin
                if (alloc) begin
                    busy[tail] <= 1'b1;
                    tail       <= tail + 1'b1;   // Wraps, depth is a power of two
                end
                if (commit_fire) begin
                    busy[head] <= 1'b0;
                    head       <= head + 1'b1;
                end
                case ({alloc, commit_fire})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: ;                   // Both or neither, no change
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rdy[tail]     <= disp.illegal;       // Illegal is done at allocation
            excp[tail]    <= disp.illegal;
            rd_q[tail]    <= disp.rd;
            wr_q[tail]    <= disp.reg_write;
            pc_q[tail]    <= disp.pc;
        end
        // Old busy guards against stale results after a flush
        if (wb_alu.valid && busy[wb_alu.tag]) begin
            rdy[wb_alu.tag]     <= 1'b1;
            value_q[wb_alu.tag] <= wb_alu.value;
        end
        if (wb_mul.valid && busy[wb_mul.tag]) begin
            rdy[wb_mul.tag]     <= 1'b1;
            value_q[wb_mul.tag] <= wb_mul.value;
        end
        if (commit_fire) begin
            commit_rd        <= rd_q[head];
            commit_value     <= value_q[head];
            commit_reg_write <= wr_q[head];
            commit_pc        <= pc_q[head];
        end
        if (excp_fire) begin
            excp_pc <= pc_q[head];               // PC of the faulting instruction
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    parameter int XLEN          = 32;             // Data path width
    parameter int ROB_DEPTH_DEF = 16;             // Default buffer entries, power of two

    // R-type encodings handled by this back end
    parameter logic [6:0] OPC_OP    = 7'b0110011; // Register-register ops
    parameter logic [6:0] F7_BASE   = 7'b0000000; // ADD, SLT, XOR, OR, AND
    parameter logic [6:0] F7_SUB    = 7'b0100000; // SUB
    parameter logic [6:0] F7_MULDIV = 7'b0000001; // M extension, only MUL here

    typedef enum logic [1:0] {
        UNIT_ALU,                                 // Single-cycle ALU
        UNIT_MUL,                                 // Three-stage multiplier
        UNIT_NONE                                 // Illegal, no unit runs it
    } unit_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT                                   // Signed compare
    } alu_op_e;

    typedef struct packed {
        unit_e           unit;                    // Target unit
        alu_op_e         alu_op;                  // Valid only for UNIT_ALU
        logic [4:0]      rd;                      // Destination register
        logic            reg_write;               // Low for x0 or illegal
        logic            illegal;                 // Raise exception at commit
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] op_a;                    // rs1 value
        logic [XLEN-1:0] op_b;                    // rs2 value
    } issue_t;

endpackage

`default_nettype wire

// ==== hdl/wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wb_if #(
    parameter int ROB_DEPTH = rob_pkg::ROB_DEPTH_DEF
);

    localparam int TAG_W = $clog2(ROB_DEPTH);    // Buffer index width

    logic                     valid;             // Result strobe, one cycle
    logic [TAG_W-1:0]         tag;               // Buffer entry of the result
    logic [rob_pkg::XLEN-1:0] value;             // Result data
    logic                     kill;              // Flush back from the buffer

    // Execution unit side
    modport source (output valid, tag, value, input kill);

    // Reorder buffer side
    modport sink (input valid, tag, value, output kill);

endinterface

`default_nettype wire

// ==== list.f ====
+incdir+test
hdl/rob_pkg.sv
hdl/wb_if.sv
hdl/inst_decode.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/reorder_buffer.sv
hdl/ooo_core_top.sv
test/tb_ooo_core.sv

// ==== test/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: unit, ALU operation (ignored unless UNIT_ALU), rd, idle gap after issue
typedef struct packed {
    rob_pkg::unit_e   unit;                      // UNIT_NONE marks an illegal encoding
    rob_pkg::alu_op_e op;
    logic [4:0]       rd;
    logic             gap;                       // 1 leaves idle cycles before the next
} vec_t;

localparam int N_VEC = 26;

vec_t vectors [N_VEC] = '{
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_ADD, 5'd1,  1'b1},  // Every ALU operation
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_SUB, 5'd2,  1'b0},
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_AND, 5'd3,  1'b1},
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_OR,  5'd4,  1'b0},
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_XOR, 5'd5,  1'b0},
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_SLT, 5'd6,  1'b1},
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_SLT, 5'd7,  1'b0},
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_ADD, 5'd0,  1'b1},  // Write to x0
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd8,  1'b1},  // Lone multiply
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd9,  1'b0},  // MUL then ALU ops
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_ADD, 5'd10, 1'b0},
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_SUB, 5'd11, 1'b0},
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_XOR, 5'd12, 1'b1},
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_ADD, 5'd13, 1'b0},  // Legal ops, then illegal
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd14, 1'b0},
    '{rob_pkg::UNIT_NONE, rob_pkg::ALU_ADD, 5'd15, 1'b0},
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd15, 1'b0},  // After the flush
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_SLT, 5'd16, 1'b0},
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd0,  1'b1},
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd17, 1'b0},  // Burst to fill the buffer
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd18, 1'b0},
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd19, 1'b0},
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd20, 1'b0},
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd21, 1'b0},
    '{rob_pkg::UNIT_MUL,  rob_pkg::ALU_ADD, 5'd22, 1'b0},
    '{rob_pkg::UNIT_ALU,  rob_pkg::ALU_OR,  5'd23, 1'b1}
};

`endif

// ==== test/tb_ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;

    localparam int XLEN       = rob_pkg::XLEN;
    localparam int TB_DEPTH   = 4;               // Small buffer so a burst fills it
    localparam int WAIT_LIMIT = 200;             // Cycles per wait loop

    `include "tb_vectors.svh"

    typedef struct packed {
        logic            is_excp;                // Exception expected instead of a commit
        logic [4:0]      rd;
        logic [XLEN-1:0] value;
        logic            wr;
        logic [XLEN-1:0] pc;
    } exp_t;

    logic            clk;
    logic            rst;
    logic            issue_valid;
    logic [31:0]     issue_instr;
    logic [XLEN-1:0] issue_pc;
    logic [XLEN-1:0] issue_op_a;
    logic [XLEN-1:0] issue_op_b;
    logic            rob_full;
    logic            commit_valid;
    logic [4:0]      commit_rd;
    logic [XLEN-1:0] commit_value;
    logic            commit_reg_write;
    logic [XLEN-1:0] commit_pc;
    logic            excp_valid;
    logic [XLEN-1:0] excp_pc;

    exp_t            exp_q [$];                  // Expected results in program order
    logic [15:0]     lfsr_state = 16'd62616;
    logic [XLEN-1:0] next_pc    = 32'h0000_0100;
    logic            saw_full   = 1'b0;          // rob_full seen high at least once

    ooo_core_top #(.ROB_DEPTH(TB_DEPTH)) i_ooo_core_top (
        .clk              (clk),
        .rst              (rst),
        .issue_valid      (issue_valid),
        .issue_instr      (issue_instr),
        .issue_pc         (issue_pc),
        .issue_op_a       (issue_op_a),
        .issue_op_b       (issue_op_b),
        .rob_full         (rob_full),
        .commit_valid     (commit_valid),
        .commit_rd        (commit_rd),
        .commit_value     (commit_value),
        .commit_reg_write (commit_reg_write),
        .commit_pc        (commit_pc),
        .excp_valid       (excp_valid),
        .excp_pc          (excp_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                  // 40 ns period
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        logic [XLEN-1:0] w;
        w = '0;
        for (int k = 0; k < XLEN; k++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            w = {w[XLEN-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // RV32 R-type fields with rs1 = x1 and rs2 = x2
    function automatic logic [31:0] encode_instr(input vec_t v);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = 7'b0000000;
        f3 = 3'b000;
        if (v.unit == rob_pkg::UNIT_NONE) begin
            return {12'h005, 5'd1, 3'b000, v.rd, 7'b0010011}; // ADDI is outside this back end
        end
        if (v.unit == rob_pkg::UNIT_MUL) begin
            f7 = 7'b0000001;
        end else begin
            case (v.op)
                rob_pkg::ALU_SUB: f7 = 7'b0100000;
                rob_pkg::ALU_SLT: f3 = 3'b010;
                rob_pkg::ALU_XOR: f3 = 3'b100;
                rob_pkg::ALU_OR:  f3 = 3'b110;
                rob_pkg::ALU_AND: f3 = 3'b111;
                default: ;                       // ADD
            endcase
        end
        return {f7, 5'd2, 5'd1, f3, v.rd, 7'b0110011};
    endfunction

    function automatic logic [XLEN-1:0] model_result(input vec_t v, input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        if (v.unit == rob_pkg::UNIT_MUL) return a * b; // Low half of product
        case (v.op)
            rob_pkg::ALU_ADD: return a + b;
            rob_pkg::ALU_SUB: return a - b;
            rob_pkg::ALU_AND: return a & b;
            rob_pkg::ALU_OR:  return a | b;
            rob_pkg::ALU_XOR: return a ^ b;
            default:          return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic check_commit(input logic [4:0] exp_rd, input logic [4:0] got_rd,
                                input logic [XLEN-1:0] exp_value,
                                input logic [XLEN-1:0] got_value,
                                input logic [XLEN-1:0] exp_pc, input logic [XLEN-1:0] got_pc,
                                input logic exp_wr, input logic got_wr);
        if (got_rd !== exp_rd || got_value !== exp_value || got_pc !== exp_pc ||
            got_wr !== exp_wr) begin
            abort_run($sformatf(
                "MISMATCH at %0t: commit pc %h rd %0d value %h wr %b, expected %h %0d %h %b",
                $time, got_pc, got_rd, got_value, got_wr, exp_pc, exp_rd, exp_value, exp_wr));
        end
    endtask

    task automatic check_excp(input logic [XLEN-1:0] exp_pc, input logic [XLEN-1:0] got_pc);
        if (got_pc !== exp_pc) begin
            abort_run($sformatf("MISMATCH at %0t: exception pc %h, expected %h",
                                $time, got_pc, exp_pc));
        end
    endtask

    task automatic wait_for_excp();
        int t;
        t = 0;
        @(negedge clk);
        while (!excp_valid) begin
            t++;
            if (t > WAIT_LIMIT) abort_run("Timed out waiting for the exception strobe");
            @(negedge clk);
        end
    endtask

    task automatic issue_row(input int idx);
        vec_t            v;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        exp_t            e;
        logic            full;
        int              t;
        v = vectors[idx];
        a = rand_word();
        b = rand_word();
        t = 0;
        @(negedge clk);
        full = rob_full;                         // Sampled while outputs are stable
        @(posedge clk);
        // Queue size also covers issues that rob_full does not show yet
        while (full || exp_q.size() >= TB_DEPTH) begin
            t++;
            if (t > WAIT_LIMIT) abort_run("Timed out waiting for room in the reorder buffer");
            issue_valid <= 1'b0;
            @(negedge clk);
            full = rob_full;
            @(posedge clk);
        end
        issue_valid <= 1'b1;
        issue_instr <= encode_instr(v);
        issue_pc    <= next_pc;
        issue_op_a  <= a;
        issue_op_b  <= b;
        e.is_excp = (v.unit == rob_pkg::UNIT_NONE);
        e.rd      = v.rd;
        e.value   = model_result(v, a, b);
        e.wr      = !e.is_excp && (v.rd != 5'd0);  // x0 is never written
        e.pc      = next_pc;
        exp_q.push_back(e);
        next_pc = next_pc + 32'd4;
        if (e.is_excp) begin
            @(posedge clk);
            issue_valid <= 1'b0;
            wait_for_excp();                     // Nothing younger until the flush
        end else if (v.gap) begin
            @(posedge clk);
            issue_valid <= 1'b0;
            repeat (2) @(posedge clk);
        end
    endtask

    // Scoreboard pops one expectation per commit or exception
    initial begin : monitor
        exp_t e;
        forever begin
            @(negedge clk);
            if (rob_full) begin
                saw_full = 1'b1;
                if (exp_q.size() < TB_DEPTH) begin     // Allocated never exceeds outstanding
                    abort_run($sformatf("MISMATCH at %0t: rob_full high with %0d outstanding",
                                        $time, exp_q.size()));
                end
            end
            if (commit_valid || excp_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("Commit or exception seen with no instruction outstanding");
                end else begin
                    e = exp_q.pop_front();
                    if (e.is_excp != excp_valid || e.is_excp == commit_valid) begin
                        abort_run($sformatf("Wrong kind of result for the instruction at pc %h",
                                            e.pc));
                    end else if (e.is_excp) begin
                        check_excp(e.pc, excp_pc);
                    end else begin
                        check_commit(e.rd, commit_rd, e.value, commit_value, e.pc, commit_pc,
                                     e.wr, commit_reg_write);
                    end
                end
            end
        end
    end

    initial begin : stimulus
        int t;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_instr = '0;
        issue_pc    = '0;
        issue_op_a  = '0;
        issue_op_b  = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (commit_valid || excp_valid || rob_full) abort_run("Outputs not low after reset");
        for (int i = 0; i < N_VEC; i++) begin
            issue_row(i);
        end
        @(posedge clk);
        issue_valid <= 1'b0;
        t = 0;
        while (exp_q.size() != 0) begin
            t++;
            if (t > WAIT_LIMIT) abort_run("Timed out waiting for the last commits");
            @(negedge clk);
        end
        repeat (5) @(negedge clk);               // Stray commits show up here
        if (saw_full) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("rob_full never went high during the multiply burst");
            $display("TEST FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
